/* flist.f */
+incdir+common
common/cache_pkg.sv
common/cache_if.sv
source/bus_front.sv
source/req_fifo.sv
cache/cache_mem.sv
cache/cache_ctrl.sv
source/cache_top.sv
sim/wb_mem_model.sv
sim/tb_cache.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and fail when the log reports a failure
cd "$(dirname "$0")" &&
  verilator --binary --timing -Wno-fatal --top-module tb_cache -f flist.f \
    -Mdir obj_dir > build.log 2>&1 &&
  ./obj_dir/Vtb_cache > sim.log 2>&1 &&
  cat sim.log &&
  ! grep -q "Result: FAILED" sim.log ||
  { echo "Simulation failed, see build.log and sim.log"; exit 1; }
echo "Simulation passed"

/* sim/tb_cache.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module tb_cache;

  localparam int WAIT_LIMIT = 4000;
  localparam logic [`CACHE_ADDR_W-1:0] ADR_FIRST = 25'h0123;
  localparam logic [`CACHE_ADDR_W-1:0] ADR_WRITE = 25'h0122;

  logic                     clk;
  logic                     rst;
  logic                     s_cyc;
  logic                     s_stb;
  logic                     s_we;
  logic [`CACHE_ADDR_W-1:0] s_adr;
  logic [`CACHE_SEL_W-1:0]  s_sel;
  logic [`CACHE_DATA_W-1:0] s_dat_w;
  wire  [`CACHE_DATA_W-1:0] s_dat_r;
  wire                      s_ack;
  wire                      m_cyc;
  wire                      m_stb;
  wire                      m_we;
  wire  [`CACHE_ADDR_W-1:0] m_adr;
  wire  [`CACHE_DATA_W-1:0] m_dat_w;
  wire  [`CACHE_DATA_W-1:0] m_dat_r;
  wire                      m_ack;
  wire                      hit;
  wire                      miss;

  logic [15:0]              lfsr;
  logic [31:0]              shadow [logic [24:0]];
  logic [24:0]              wr_adr_log [$];
  logic [31:0]              wr_dat_log [$];
  int                       rd_beats = 0;
  int                       wr_beats = 0;
  int                       errors = 0;
  int                       tests_run = 0;

  cache_top i_cache_top (
    .clk_i   (clk),     .rst_i   (rst),
    .s_cyc_i (s_cyc),   .s_stb_i (s_stb),   .s_we_i  (s_we),
    .s_adr_i (s_adr),   .s_sel_i (s_sel),   .s_dat_i (s_dat_w),
    .s_dat_o (s_dat_r), .s_ack_o (s_ack),
    .m_cyc_o (m_cyc),   .m_stb_o (m_stb),   .m_we_o  (m_we),
    .m_adr_o (m_adr),   .m_dat_o (m_dat_w), .m_dat_i (m_dat_r),
    .m_ack_i (m_ack),   .hit_o   (hit),     .miss_o  (miss)
  );

  wb_mem_model i_mem_model (
    .clk_i (clk),   .rst_i (rst),   .cyc_i (m_cyc), .stb_i (m_stb),
    .we_i  (m_we),  .adr_i (m_adr), .dat_i (m_dat_w),
    .dat_o (m_dat_r), .ack_o (m_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Log every completed master beat
  always @(negedge clk) begin
    if (m_stb !== m_cyc) begin
      report_failure("m_stb_o does not follow m_cyc_o on the master port");
    end
    if (m_cyc && m_stb && m_ack) begin
      if (m_we) begin
        wr_beats++;
        wr_adr_log.push_back(m_adr);
        wr_dat_log.push_back(m_dat_w);
      end else begin
        rd_beats++;
      end
    end
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic logic [31:0] expected_word(input logic [24:0] adr);
    if (shadow.exists(adr)) begin
      return shadow[adr];
    end
    return {7'd0, adr} * 32'd3;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] dat,
                                              input logic [3:0]  sel);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = dat[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("ERR %s: expected %h, actual %h", name, exp, act);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout: %s", what);
    $display("Tests run: %0d, errors: %0d", tests_run, errors + 1);
    $display("Result: FAILED");
    $finish;
  endtask

  task automatic bus_write(input logic [24:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, output int cycles);
    int n;
    n = 0;
    @(posedge clk);
    s_cyc   <= 1'b1;
    s_stb   <= 1'b1;
    s_we    <= 1'b1;
    s_adr   <= adr;
    s_dat_w <= dat;
    s_sel   <= sel;
    do begin
      @(negedge clk);
      n++;
    end while (!s_ack && n < WAIT_LIMIT);
    if (!s_ack) begin
      abort_on_timeout("a write on the slave port was never acknowledged");
    end else begin
      @(posedge clk);
      s_cyc <= 1'b0;
      s_stb <= 1'b0;
      s_we  <= 1'b0;
      shadow[adr] = merge_bytes(expected_word(adr), dat, sel);
      cycles = n;
    end
  endtask

  // Also records whether hit_o or miss_o rose while the read was pending
  task automatic bus_read(input logic [24:0] adr, output logic [31:0] dat,
                          output logic saw_hit, output logic saw_miss);
    int n;
    n = 0;
    saw_hit = 1'b0;
    saw_miss = 1'b0;
    @(posedge clk);
    s_cyc <= 1'b1;
    s_stb <= 1'b1;
    s_we  <= 1'b0;
    s_adr <= adr;
    do begin
      @(negedge clk);
      n++;
      saw_hit  = saw_hit || hit;
      saw_miss = saw_miss || miss;
    end while (!s_ack && n < WAIT_LIMIT);
    if (!s_ack) begin
      abort_on_timeout("a read on the slave port was never acknowledged");
    end else begin
      dat = s_dat_r;
      @(posedge clk);
      s_cyc <= 1'b0;
      s_stb <= 1'b0;
    end
  endtask

  task automatic read_after_reset;
    logic [31:0] rd;
    logic        saw_hit;
    logic        saw_miss;
    int          rd0;
    int          wr0;
    rd0 = rd_beats;
    wr0 = wr_beats;
    bus_read(ADR_FIRST, rd, saw_hit, saw_miss);
    tests_run++;
    if (rd !== expected_word(ADR_FIRST)) begin
      report_mismatch("read_after_reset", expected_word(ADR_FIRST), rd);
    end
    if (!saw_miss) begin
      report_failure("read_after_reset: miss_o never rose during the request");
    end
    if (rd_beats - rd0 != 4 || wr_beats != wr0) begin
      report_failure("read_after_reset: the refill was not exactly four master reads");
    end
  endtask

  task automatic read_same_line;
    logic [24:0] adr;
    logic [31:0] rd;
    logic        saw_hit;
    logic        saw_miss;
    int          rd0;
    int          wr0;
    adr = ADR_FIRST - 25'd2;
    rd0 = rd_beats;
    wr0 = wr_beats;
    bus_read(adr, rd, saw_hit, saw_miss);
    tests_run++;
    if (rd !== expected_word(adr)) begin
      report_mismatch("read_same_line", expected_word(adr), rd);
    end
    if (!saw_hit || saw_miss) begin
      report_failure("read_same_line: the read was not served as a hit");
    end
    if (rd_beats != rd0 || wr_beats != wr0) begin
      report_failure("read_same_line: a master cycle ran on a hit");
    end
  endtask

  task automatic partial_write;
    logic [31:0] rd;
    logic        saw_hit;
    logic        saw_miss;
    int          cycles;
    bus_write(ADR_WRITE, 32'hA5C3_5A3C, 4'b0101, cycles);
    tests_run++;
    // Accepted in the first cycle, so the ack shows up in the second
    if (cycles != 2) begin
      report_failure("partial_write: the write ack did not follow acceptance by one cycle");
    end
    bus_read(ADR_WRITE, rd, saw_hit, saw_miss);
    if (rd !== expected_word(ADR_WRITE)) begin
      report_mismatch("partial_write", expected_word(ADR_WRITE), rd);
    end
  endtask

  task automatic dirty_eviction;
    logic [24:0] old_base;
    logic [24:0] adr;
    logic [31:0] rd;
    logic        saw_hit;
    logic        saw_miss;
    int          rd0;
    old_base = ADR_WRITE & ~25'h3;
    adr = ADR_WRITE + 25'h1000;
    rd0 = rd_beats;
    wr_adr_log.delete();
    wr_dat_log.delete();
    bus_read(adr, rd, saw_hit, saw_miss);
    tests_run++;
    if (rd !== expected_word(adr)) begin
      report_mismatch("dirty_eviction read", expected_word(adr), rd);
    end
    if (!saw_miss) begin
      report_failure("dirty_eviction: miss_o never rose during the request");
    end
    if (rd_beats - rd0 != 4) begin
      report_failure("dirty_eviction: the refill was not exactly four master reads");
    end
    if (wr_adr_log.size() != 4) begin
      report_failure("dirty_eviction: the write-back was not exactly four master writes");
    end else begin
      for (int k = 0; k < 4; k++) begin
        if (wr_adr_log[k] !== old_base + 25'(k)) begin
          report_mismatch("dirty_eviction address", 32'(old_base + 25'(k)), 32'(wr_adr_log[k]));
        end
        if (wr_dat_log[k] !== expected_word(old_base + 25'(k))) begin
          report_mismatch("dirty_eviction data", expected_word(old_base + 25'(k)),
                          wr_dat_log[k]);
        end
      end
    end
    for (int k = 0; k < 4; k++) begin
      if (i_mem_model.mem[int'(old_base) + k] !== expected_word(old_base + 25'(k))) begin
        report_mismatch("dirty_eviction memory", expected_word(old_base + 25'(k)),
                        i_mem_model.mem[int'(old_base) + k]);
      end
    end
  endtask

  // Same index and six tags, so each write after the first evicts a dirty line
  task automatic posted_writes;
    logic [24:0] adr [6];
    logic [31:0] dat;
    logic [31:0] bits;
    logic [31:0] rd;
    logic        saw_hit;
    logic        saw_miss;
    int          cycles;
    int          wr0;
    int          wr_at_ack;
    wr0 = i_mem_model.write_beats;
    for (int k = 0; k < 6; k++) begin
      adr[k] = 25'h0344 + (25'(k) << 12);
      take_bits(32, dat);
      take_bits(4, bits);
      bus_write(adr[k], dat, bits[3:0], cycles);
    end
    bus_read(adr[5], rd, saw_hit, saw_miss);
    wr_at_ack = i_mem_model.write_beats;
    tests_run++;
    if (rd !== expected_word(adr[5])) begin
      report_mismatch("posted_writes read", expected_word(adr[5]), rd);
    end
    if (wr_at_ack - wr0 != 20) begin
      report_failure("posted_writes: the read was acked before all write-backs finished");
    end
    repeat (20) @(posedge clk);
    if (i_mem_model.write_beats != wr_at_ack) begin
      report_failure("posted_writes: a write beat was counted after the read's ack");
    end
    for (int k = 0; k < 6; k++) begin
      bus_read(adr[k], rd, saw_hit, saw_miss);
      if (rd !== expected_word(adr[k])) begin
        report_mismatch("posted_writes readback", expected_word(adr[k]), rd);
      end
    end
  endtask

  initial begin
    rst     = 1'b1;
    s_cyc   = 1'b0;
    s_stb   = 1'b0;
    s_we    = 1'b0;
    s_adr   = '0;
    s_sel   = '0;
    s_dat_w = '0;
    lfsr    = 16'd30348;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    read_after_reset();
    read_same_line();
    partial_write();
    dirty_eviction();
    posted_writes();
    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/wb_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module wb_mem_model (
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire                      cyc_i,
  input  wire                      stb_i,
  input  wire                      we_i,
  input  wire [`CACHE_ADDR_W-1:0]  adr_i,
  input  wire [`CACHE_DATA_W-1:0]  dat_i,
  output logic [`CACHE_DATA_W-1:0] dat_o,
  output logic                     ack_o
);

  localparam int WORDS = 1 << 15;

  logic [`CACHE_DATA_W-1:0] mem [WORDS];
  int unsigned              write_beats;
  logic [15:0]              lfsr;
  logic [15:0]              lfsr_next1;
  logic [15:0]              lfsr_next2;
  logic [1:0]               wait_cnt;
  logic [14:0]              word;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  assign lfsr_next1 = lfsr_step(lfsr);
  assign lfsr_next2 = lfsr_step(lfsr_next1);
  assign word       = adr_i[14:0];

  // Each word starts as its own address times three
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = 32'(i * 3);
    end
  end

  always @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ack_o       <= 1'b0;
      dat_o       <= '0;
      wait_cnt    <= '0;
      lfsr        <= 16'd30348;
      write_beats <= 0;
    end else if (ack_o) begin
      // Two fresh LFSR bits set the delay of the next beat
      ack_o    <= 1'b0;
      wait_cnt <= {lfsr_next1[0], lfsr[0]};
      lfsr     <= lfsr_next2;
    end else if (cyc_i && stb_i) begin
      if (wait_cnt != 2'd0) begin
        wait_cnt <= wait_cnt - 2'd1;
      end else begin
        ack_o <= 1'b1;
        if (we_i) begin
          mem[word]   <= dat_i;
          write_beats <= write_beats + 1;
        end else begin
          dat_o <= mem[word];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* source/cache_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module cache_top (
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire                      s_cyc_i,
  input  wire                      s_stb_i,
  input  wire                      s_we_i,
  input  wire [`CACHE_ADDR_W-1:0]  s_adr_i,
  input  wire [`CACHE_SEL_W-1:0]   s_sel_i,
  input  wire [`CACHE_DATA_W-1:0]  s_dat_i,
  output logic [`CACHE_DATA_W-1:0] s_dat_o,
  output logic                     s_ack_o,
  output logic                     m_cyc_o,
  output logic                     m_stb_o,
  output logic                     m_we_o,
  output logic [`CACHE_ADDR_W-1:0] m_adr_o,
  output logic [`CACHE_DATA_W-1:0] m_dat_o,
  input  wire [`CACHE_DATA_W-1:0]  m_dat_i,
  input  wire                      m_ack_i,
  output logic                     hit_o,
  output logic                     miss_o
);

  logic                  push;
  cache_pkg::cache_req_t push_req;
  logic                  fifo_full;
  logic                  fifo_empty;
  logic                  done;

  cache_req_if  req_if ();
  cache_line_if line_if ();

  // Memory side is single-beat per strobe
  assign m_stb_o = m_cyc_o;

  bus_front i_bus_front (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cyc_i        (s_cyc_i),
    .stb_i        (s_stb_i),
    .we_i         (s_we_i),
    .adr_i        (s_adr_i),
    .sel_i        (s_sel_i),
    .dat_i        (s_dat_i),
    .push_o       (push),
    .req_o        (push_req),
    .ack_o        (s_ack_o),
    .fifo_full_i  (fifo_full),
    .fifo_empty_i (fifo_empty),
    .done_i       (done)
  );

  req_fifo i_req_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (push),
    .data_i  (push_req),
    .full_o  (fifo_full),
    .empty_o (fifo_empty),
    .req_if  (req_if.fifo)
  );

  cache_ctrl i_cache_ctrl (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_if   (req_if.ctrl),
    .line_if  (line_if.ctrl),
    .m_cyc_o  (m_cyc_o),
    .m_we_o   (m_we_o),
    .m_adr_o  (m_adr_o),
    .m_dat_o  (m_dat_o),
    .m_dat_i  (m_dat_i),
    .m_ack_i  (m_ack_i),
    .rd_dat_o (s_dat_o),
    .done_o   (done),
    .hit_o    (hit_o),
    .miss_o   (miss_o)
  );

  cache_mem i_cache_mem (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .line_if (line_if.mem)
  );

endmodule

`default_nettype wire

/* cache/cache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module cache_ctrl (
  input  wire                      clk_i,
  input  wire                      rst_i,
  cache_req_if.ctrl                req_if,
  cache_line_if.ctrl               line_if,
  output logic                     m_cyc_o,
  output logic                     m_we_o,
  output logic [`CACHE_ADDR_W-1:0] m_adr_o,
  output logic [`CACHE_DATA_W-1:0] m_dat_o,
  input  wire [`CACHE_DATA_W-1:0]  m_dat_i,
  input  wire                      m_ack_i,
  output logic [`CACHE_DATA_W-1:0] rd_dat_o,
  output logic                     done_o,
  output logic                     hit_o,
  output logic                     miss_o
);

  cache_pkg::ctrl_state_e state, state_next;

  logic [`CACHE_INDEX_W-1:0] init_cnt;
  cache_pkg::cache_req_t     req_q;
  cache_pkg::line_t          line_q;
  cache_pkg::line_t          merge_line;
  logic [`CACHE_TAG_W-1:0]   req_tag;
  logic [`CACHE_INDEX_W-1:0] req_index;
  logic [`CACHE_WSEL_W-1:0]  req_wsel;
  logic                      line_hit;
  logic                      in_fill;
  logic                      in_flush;
  logic [`CACHE_WSEL_W-1:0]  beat;

  assign req_tag   = req_q.adr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  assign req_index = req_q.adr[`CACHE_WSEL_W +: `CACHE_INDEX_W];
  assign req_wsel  = req_q.adr[`CACHE_WSEL_W-1:0];
  assign line_hit  = line_if.rdata.valid && (line_if.rdata.tag == req_tag);

  assign req_if.pop = (state == cache_pkg::CTRL_IDLE) && req_if.valid;

  assign line_if.index = (state == cache_pkg::CTRL_INIT) ? init_cnt : req_index;
  assign line_if.wdata = (state == cache_pkg::CTRL_INIT) ? '0 : line_q;
  assign line_if.wren  = (state == cache_pkg::CTRL_INIT) ||
                         (state == cache_pkg::CTRL_FILL_WR) ||
                         (state == cache_pkg::CTRL_FLUSH_WR) ||
                         ((state == cache_pkg::CTRL_DONE) && req_q.we);

  assign done_o = (state == cache_pkg::CTRL_DONE);
  assign hit_o  = (state == cache_pkg::CTRL_HIT);
  assign miss_o = (state == cache_pkg::CTRL_MISS);

  always_comb begin
    in_fill  = 1'b0;
    in_flush = 1'b0;
    beat     = '0;
    case (state)
      cache_pkg::CTRL_FILL0:  in_fill = 1'b1;
      cache_pkg::CTRL_FILL1:  begin in_fill = 1'b1; beat = 2'd1; end
      cache_pkg::CTRL_FILL2:  begin in_fill = 1'b1; beat = 2'd2; end
      cache_pkg::CTRL_FILL3:  begin in_fill = 1'b1; beat = 2'd3; end
      cache_pkg::CTRL_FLUSH0: in_flush = 1'b1;
      cache_pkg::CTRL_FLUSH1: begin in_flush = 1'b1; beat = 2'd1; end
      cache_pkg::CTRL_FLUSH2: begin in_flush = 1'b1; beat = 2'd2; end
      cache_pkg::CTRL_FLUSH3: begin in_flush = 1'b1; beat = 2'd3; end
      default: ;
    endcase
  end

  // Write-back goes to the old tag, which line_q still holds during the flush
  assign m_cyc_o = in_fill || in_flush;
  assign m_we_o  = in_flush;
  assign m_adr_o = {(in_flush ? line_q.tag : req_tag), req_index, beat};
  assign m_dat_o = line_q.data[beat];

  always_comb begin
    merge_line = line_if.rdata;
    for (int b = 0; b < `CACHE_SEL_W; b++) begin
      if (req_q.sel[b]) begin
        merge_line.data[req_wsel][8*b +: 8] = req_q.dat[8*b +: 8];
      end
    end
    merge_line.dirty[req_wsel] = 1'b1;
  end

  always_comb begin
    state_next = state;
    case (state)
      cache_pkg::CTRL_INIT: begin
        if (init_cnt == '0) begin
          state_next = cache_pkg::CTRL_IDLE;
        end
      end
      cache_pkg::CTRL_IDLE: begin
        if (req_if.valid) begin
          state_next = cache_pkg::CTRL_LOOKUP;
        end
      end
      cache_pkg::CTRL_LOOKUP:  state_next = cache_pkg::CTRL_COMPARE;
      cache_pkg::CTRL_COMPARE: state_next = line_hit ? cache_pkg::CTRL_HIT : cache_pkg::CTRL_MISS;
      cache_pkg::CTRL_HIT:     state_next = cache_pkg::CTRL_DONE;
      cache_pkg::CTRL_MISS: begin
        if (line_if.rdata.valid && |line_if.rdata.dirty) begin
          state_next = cache_pkg::CTRL_FLUSH0;
        end else begin
          state_next = cache_pkg::CTRL_FILL0;
        end
      end
      // Beat states are numbered in order, so an ack steps to the next one
      cache_pkg::CTRL_FILL0, cache_pkg::CTRL_FILL1, cache_pkg::CTRL_FILL2,
      cache_pkg::CTRL_FILL3, cache_pkg::CTRL_FLUSH0, cache_pkg::CTRL_FLUSH1,
      cache_pkg::CTRL_FLUSH2, cache_pkg::CTRL_FLUSH3: begin
        if (m_ack_i) begin
          state_next = cache_pkg::ctrl_state_e'(state + 1'b1);
        end
      end
      cache_pkg::CTRL_FILL_WR:  state_next = cache_pkg::CTRL_LOOKUP;
      cache_pkg::CTRL_FLUSH_WR: state_next = cache_pkg::CTRL_FILL0;
      default:                  state_next = cache_pkg::CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state    <= cache_pkg::CTRL_INIT;
      init_cnt <= '1;
    end else begin
      state <= state_next;
      if (state == cache_pkg::CTRL_INIT) begin
        init_cnt <= init_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_if.pop) begin
      req_q <= req_if.req;
    end
    if (state == cache_pkg::CTRL_HIT) begin
      if (req_q.we) begin
        line_q <= merge_line;
      end else begin
        rd_dat_o <= line_if.rdata.data[req_wsel];
      end
    end
    if (state == cache_pkg::CTRL_MISS) begin
      line_q <= line_if.rdata;
    end
    if (in_flush && m_ack_i) begin
      line_q.dirty[beat] <= 1'b0;
    end
    if (in_fill && m_ack_i) begin
      line_q.valid       <= 1'b1;
      line_q.tag         <= req_tag;
      line_q.dirty[beat] <= 1'b0;
      line_q.data[beat]  <= m_dat_i;
    end
  end

endmodule

`default_nettype wire

/* cache/cache_mem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module cache_mem (
  input  wire        clk_i,
  input  wire        rst_i,
  cache_line_if.mem  line_if
);

  localparam int unsigned LINES = 1 << `CACHE_INDEX_W;

  cache_pkg::line_t mem [LINES];

  always_ff @(posedge clk_i) begin
    if (line_if.wren) begin
      mem[line_if.index] <= line_if.wdata;
    end
  end

  // Read returns the old contents when the same line is written in that cycle
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      line_if.rdata <= '0;
    end else begin
      line_if.rdata <= mem[line_if.index];
    end
  end

endmodule

`default_nettype wire

/* source/req_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module req_fifo (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire                   push_i,
  input  cache_pkg::cache_req_t data_i,
  output logic                  full_o,
  output logic                  empty_o,
  cache_req_if.fifo             req_if
);

  cache_pkg::cache_req_t mem [`REQ_FIFO_DEPTH];

  logic [`REQ_FIFO_PTR_W-1:0] wr_ptr;
  logic [`REQ_FIFO_PTR_W-1:0] rd_ptr;
  logic [`REQ_FIFO_PTR_W:0]   count;
  logic                       do_push;
  logic                       do_pop;

  assign full_o  = (count == `REQ_FIFO_DEPTH);
  assign empty_o = (count == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = req_if.pop && !empty_o;

  // Head entry is visible without a read strobe
  assign req_if.valid = !empty_o;
  assign req_if.req   = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/bus_front.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module bus_front (
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire                      cyc_i,
  input  wire                      stb_i,
  input  wire                      we_i,
  input  wire [`CACHE_ADDR_W-1:0]  adr_i,
  input  wire [`CACHE_SEL_W-1:0]   sel_i,
  input  wire [`CACHE_DATA_W-1:0]  dat_i,
  output logic                     push_o,
  output cache_pkg::cache_req_t    req_o,
  output logic                     ack_o,
  input  wire                      fifo_full_i,
  input  wire                      fifo_empty_i,
  input  wire                      done_i
);

  cache_pkg::bus_state_e state, state_next;

  assign push_o = (state == cache_pkg::BUS_IDLE) && cyc_i && stb_i && !fifo_full_i;
  assign req_o  = '{we: we_i, adr: adr_i, dat: dat_i, sel: sel_i};
  assign ack_o  = (state == cache_pkg::BUS_ACK);

  always_comb begin
    state_next = state;
    case (state)
      cache_pkg::BUS_IDLE: begin
        if (push_o) begin
          state_next = we_i ? cache_pkg::BUS_ACK : cache_pkg::BUS_READ_WAIT;
        end
      end
      // A read may only finish once everything queued ahead of it is done
      cache_pkg::BUS_READ_WAIT: begin
        if (fifo_empty_i && done_i) begin
          state_next = cache_pkg::BUS_ACK;
        end
      end
      default: state_next = cache_pkg::BUS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state <= cache_pkg::BUS_IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

`default_nettype wire

/* common/cache_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

// Head of the request FIFO as seen by the controller
interface cache_req_if;
  logic                  valid;
  logic                  pop;
  cache_pkg::cache_req_t req;

  modport fifo (
    output valid,
    output req,
    input  pop
  );

  modport ctrl (
    input  valid,
    input  req,
    output pop
  );
endinterface

// Line RAM access, rdata follows index by one clock
interface cache_line_if;
  logic [`CACHE_INDEX_W-1:0] index;
  logic                      wren;
  cache_pkg::line_t          wdata;
  cache_pkg::line_t          rdata;

  modport ctrl (
    output index,
    output wren,
    output wdata,
    input  rdata
  );

  modport mem (
    input  index,
    input  wren,
    input  wdata,
    output rdata
  );
endinterface

`default_nettype wire

/* common/cache_pkg.sv */
`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

  typedef enum logic [4:0] {
    CTRL_INIT,
    CTRL_IDLE,
    CTRL_LOOKUP,
    CTRL_COMPARE,
    CTRL_HIT,
    CTRL_MISS,
    CTRL_FILL0,
    CTRL_FILL1,
    CTRL_FILL2,
    CTRL_FILL3,
    CTRL_FILL_WR,
    CTRL_FLUSH0,
    CTRL_FLUSH1,
    CTRL_FLUSH2,
    CTRL_FLUSH3,
    CTRL_FLUSH_WR,
    CTRL_DONE
  } ctrl_state_e;

  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_READ_WAIT,
    BUS_ACK
  } bus_state_e;

  typedef struct packed {
    logic                     we;
    logic [`CACHE_ADDR_W-1:0] adr;
    logic [`CACHE_DATA_W-1:0] dat;
    logic [`CACHE_SEL_W-1:0]  sel;
  } cache_req_t;

  typedef struct packed {
    logic                                       valid;
    logic [`CACHE_WORDS-1:0]                    dirty;
    logic [`CACHE_TAG_W-1:0]                    tag;
    logic [`CACHE_WORDS-1:0][`CACHE_DATA_W-1:0] data;
  } line_t;

endpackage

`default_nettype wire

/* common/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Word address from the CPU, 32K lines worth of tags over 4-word lines
`define CACHE_ADDR_W 25
`define CACHE_DATA_W 32

// Address split is {tag, index, word select}
`define CACHE_TAG_W 13
`define CACHE_INDEX_W 10
`define CACHE_WSEL_W 2
`define CACHE_WORDS 4

// One select bit per byte lane
`define CACHE_SEL_W 4

`define REQ_FIFO_DEPTH 4
`define REQ_FIFO_PTR_W 2

`endif
